//--- compile.f
verilog/zxuno_pkg.sv
verilog/zxreg_if.sv
verilog/zxuno_reg_port.sv
verilog/coreid_reg.sv
verilog/option_regs.sv
verilog/scandoubler_ctrl.sv
verilog/cpu_data_mux.sv
verilog/zxuno_io_top.sv
tb/zxuno_io_asserts.sv
tb/tb_zxuno_io.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -f compile.f --top-module tb_zxuno_io -o tb_sim \
  && ./obj_dir/tb_sim 2>&1 | tee sim.log

grep -qx "RESULT: PASS" sim.log \
  && echo "Simulation passed" \
  || { echo "Simulation failed"; exit 1; }

//--- tb/tb_zxuno_io.sv
`timescale 1ns/1ns
`default_nettype none

module tb_zxuno_io import zxuno_pkg::*; ();

  localparam int                       CORE_ID_LEN  = 8;
  localparam logic [8*CORE_ID_LEN-1:0] CORE_ID      = "ZXUNO-IO";
  localparam string                    CORE_ID_TEXT = "ZXUNO-IO";
  localparam logic [7:0]               SCNDBL_RESET = 8'h21;

  localparam int NUM_RANDOM_WRITES = 200;
  localparam int NUM_KBD_STEPS     = 60;

  // Reset checks, register writes, core id, intack and keyboard sections
  localparam int NUM_ACCESSES = 7 + 3 * NUM_RANDOM_WRITES + (CORE_ID_LEN + 6) + 5
                                + (1 + 2 * NUM_KBD_STEPS);
  // Each access takes at most 4 strobe and 3 idle cycles
  localparam int TIMEOUT_CYCLES = NUM_ACCESSES * (4 + 3) + 100;

  logic       clk;
  logic       rst_n;
  cpu_addr_t  a;
  logic       iorq_n;
  logic       rd_n;
  logic       wr_n;
  logic       m1_n;
  data_t      din;
  data_t      dout;
  logic       video_output_change;
  logic       turbo_boost;
  logic       vga_enable;
  logic       scanlines_enable;
  freq_opt_t  freq_option;
  logic       csync_option;
  cpu_speed_t cpu_speed;
  data_t      dev_options;

  zxuno_io_top #(
    .CORE_ID_LEN  (CORE_ID_LEN),
    .CORE_ID      (CORE_ID),
    .SCNDBL_RESET (SCNDBL_RESET)
  ) DUT (
    .clk (clk), .rst_n (rst_n), .a (a), .iorq_n (iorq_n), .rd_n (rd_n),
    .wr_n (wr_n), .m1_n (m1_n), .din (din), .dout (dout),
    .video_output_change (video_output_change), .turbo_boost (turbo_boost),
    .vga_enable (vga_enable), .scanlines_enable (scanlines_enable),
    .freq_option (freq_option), .csync_option (csync_option),
    .cpu_speed (cpu_speed), .dev_options (dev_options)
  );

  always #20 clk = ~clk;

  // ----------------------------------------------------------
  // Random bits and reference model state
  // ----------------------------------------------------------
  logic [31:0] lfsr;
  int          check_count;
  int          error_count;
  int          cycle_count;
  regaddr_t    mdl_regaddr;
  data_t       mdl_scratch;
  data_t       mdl_devopt;
  data_t       mdl_scndbl;
  int          mdl_coreid_idx;

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic take_bits(input int n, output logic [31:0] val);
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_next(lfsr);
      val = {val[30:0], lfsr[0]};
    end
  endtask

  function automatic data_t coreid_char(input int idx);
    if (idx < CORE_ID_LEN) begin
      return CORE_ID_TEXT[idx];
    end
    return 8'h00;
  endfunction

  function automatic data_t expected_read(input cpu_addr_t addr, input logic m1);
    if (!m1) begin
      return INTACK_VALUE;
    end
    if (addr == ZXUNO_ADDR_PORT) begin
      return mdl_regaddr;
    end
    if (addr != ZXUNO_DATA_PORT) begin
      return IDLE_BUS_VALUE;
    end
    case (mdl_regaddr)
      REG_COREID:     return coreid_char(mdl_coreid_idx);
      REG_SCRATCH:    return mdl_scratch;
      REG_DEVOPTIONS: return mdl_devopt;
      REG_SCNDBLCTRL: return mdl_scndbl;
      default:        return IDLE_BUS_VALUE;
    endcase
  endfunction

  // ----------------------------------------------------------
  // Compare tasks
  // ----------------------------------------------------------
  task automatic check_byte(input data_t got, input data_t exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t ns: %s got %02h expected %02h", $time, what, got, exp);
    end
  endtask

  task automatic check_speed(input cpu_speed_t got, input cpu_speed_t exp);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t ns: cpu_speed got %0d expected %0d", $time, got, exp);
    end
  endtask

  task automatic check_outputs();
    check_byte(dev_options, mdl_devopt, "dev_options");
    check_byte({2'b00, csync_option, freq_option, scanlines_enable, vga_enable},
               {2'b00, mdl_scndbl[5:0]}, "scandoubler outputs");
    check_speed(cpu_speed, turbo_boost ? TURBO_SPEED : mdl_scndbl[7:6]);
  endtask

  // ----------------------------------------------------------
  // Bus tasks start and end on a falling edge
  // ----------------------------------------------------------
  task automatic bus_write(input cpu_addr_t addr, input data_t data, input logic kbd_pulse);
    logic [31:0] r;
    int          len;
    int          gap;
    take_bits(2, r);
    len = 2 + r % 3;
    take_bits(2, r);
    gap = 1 + r % 3;
    a = addr;
    din = data;
    iorq_n = 1'b0;
    wr_n = 1'b0;
    video_output_change = kbd_pulse;
    for (int i = 0; i < len; i++) begin
      @(negedge clk);
      video_output_change = 1'b0;
    end
    iorq_n = 1'b1;
    wr_n = 1'b1;
    repeat (gap) @(negedge clk);
    // Keyboard toggle goes into the model first so a register write overrides it
    if (kbd_pulse) begin
      mdl_scndbl[0] = ~mdl_scndbl[0];
    end
    if (addr == ZXUNO_ADDR_PORT) begin
      mdl_regaddr = data;
      mdl_coreid_idx = 0;
    end else if (addr == ZXUNO_DATA_PORT) begin
      case (mdl_regaddr)
        REG_SCRATCH:    mdl_scratch = data;
        REG_DEVOPTIONS: mdl_devopt = data;
        REG_SCNDBLCTRL: mdl_scndbl = data;
        default:        ;
      endcase
    end
  endtask

  task automatic read_check(input cpu_addr_t addr, input logic m1, input string what);
    logic [31:0] r;
    int          len;
    int          gap;
    data_t       exp;
    data_t       got;
    take_bits(2, r);
    len = 2 + r % 3;
    take_bits(2, r);
    gap = 1 + r % 3;
    exp = expected_read(addr, m1);
    a = addr;
    iorq_n = 1'b0;
    rd_n = 1'b0;
    m1_n = m1;
    repeat (len) @(negedge clk);
    got = dout;
    iorq_n = 1'b1;
    rd_n = 1'b1;
    m1_n = 1'b1;
    repeat (gap) @(negedge clk);
    check_byte(got, exp, what);
    if (addr == ZXUNO_DATA_PORT && mdl_regaddr == REG_COREID && mdl_coreid_idx < CORE_ID_LEN) begin
      mdl_coreid_idx++;
    end
  endtask

  task automatic kbd_pulse_only();
    video_output_change = 1'b1;
    @(negedge clk);
    video_output_change = 1'b0;
    @(negedge clk);
    mdl_scndbl[0] = ~mdl_scndbl[0];
  endtask

  // ----------------------------------------------------------
  // Timeout
  // ----------------------------------------------------------
  initial begin
    cycle_count = 0;
    while (cycle_count < TIMEOUT_CYCLES) begin
      @(posedge clk);
      cycle_count++;
    end
    $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
    $display("RESULT: FAIL");
    $finish;
  end

  // ----------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------
  initial begin
    logic [31:0] r;
    regaddr_t    target;
    int          assert_fails;
    clk = 1'b0;
    rst_n = 1'b0;
    a = '0;
    iorq_n = 1'b1;
    rd_n = 1'b1;
    wr_n = 1'b1;
    m1_n = 1'b1;
    din = '0;
    video_output_change = 1'b0;
    turbo_boost = 1'b0;
    lfsr = 32'h8c;
    check_count = 0;
    error_count = 0;
    mdl_regaddr = '0;
    mdl_scratch = '0;
    mdl_devopt = '0;
    mdl_scndbl = SCNDBL_RESET;
    mdl_coreid_idx = 0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);

    // Reset values
    read_check(ZXUNO_ADDR_PORT, 1'b1, "reset regaddr");
    bus_write(ZXUNO_ADDR_PORT, REG_SCRATCH, 1'b0);
    read_check(ZXUNO_DATA_PORT, 1'b1, "reset scratch");
    bus_write(ZXUNO_ADDR_PORT, REG_DEVOPTIONS, 1'b0);
    read_check(ZXUNO_DATA_PORT, 1'b1, "reset devoptions");
    bus_write(ZXUNO_ADDR_PORT, REG_SCNDBLCTRL, 1'b0);
    read_check(ZXUNO_DATA_PORT, 1'b1, "reset scandoubler");
    check_outputs();

    // Random register writes with readback
    for (int i = 0; i < NUM_RANDOM_WRITES; i++) begin
      take_bits(2, r);
      case (r[1:0])
        2'd1:    target = REG_DEVOPTIONS;
        2'd2:    target = REG_SCNDBLCTRL;
        default: target = REG_SCRATCH;
      endcase
      bus_write(ZXUNO_ADDR_PORT, target, 1'b0);
      take_bits(8, r);
      bus_write(ZXUNO_DATA_PORT, r[7:0], 1'b0);
      read_check(ZXUNO_DATA_PORT, 1'b1, "register readback");
      check_outputs();
    end

    // Core id string and its restart on rewrite of the same number
    bus_write(ZXUNO_ADDR_PORT, REG_COREID, 1'b0);
    for (int i = 0; i < CORE_ID_LEN + 2; i++) begin
      read_check(ZXUNO_DATA_PORT, 1'b1, "core id character");
    end
    bus_write(ZXUNO_ADDR_PORT, REG_COREID, 1'b0);
    read_check(ZXUNO_DATA_PORT, 1'b1, "core id restart");
    read_check(ZXUNO_DATA_PORT, 1'b1, "core id restart");

    // Interrupt acknowledge and unmapped reads
    bus_write(ZXUNO_ADDR_PORT, REG_SCRATCH, 1'b0);
    read_check(ZXUNO_ADDR_PORT, 1'b0, "intack");
    bus_write(ZXUNO_ADDR_PORT, 8'h55, 1'b0);
    read_check(ZXUNO_DATA_PORT, 1'b1, "unmapped register");
    read_check(16'h00FE, 1'b1, "unmapped port");

    // Keyboard shortcuts against CPU writes
    bus_write(ZXUNO_ADDR_PORT, REG_SCNDBLCTRL, 1'b0);
    for (int i = 0; i < NUM_KBD_STEPS; i++) begin
      take_bits(1, r);
      turbo_boost = r[0];
      take_bits(2, r);
      case (r[1:0])
        2'd0: kbd_pulse_only();
        2'd1: begin
          take_bits(8, r);
          bus_write(ZXUNO_DATA_PORT, r[7:0], 1'b1);
        end
        2'd2: begin
          take_bits(8, r);
          bus_write(ZXUNO_DATA_PORT, r[7:0], 1'b0);
        end
        default: @(negedge clk);
      endcase
      read_check(ZXUNO_DATA_PORT, 1'b1, "scandoubler readback");
      check_outputs();
    end
    turbo_boost = 1'b0;

    assert_fails = DUT.u_asserts.fail_count;
    $display("Checks: %0d, mismatches: %0d, assertion failures: %0d",
             check_count, error_count, assert_fails);
    if (error_count == 0 && assert_fails == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb/zxuno_io_asserts.sv
`timescale 1ns/1ns
`default_nettype none

module zxuno_io_asserts import zxuno_pkg::*; (
  input logic       clk,
  input logic       rst_n,
  input logic       regwr,
  input logic       regrd,
  input logic       turbo_boost,
  input cpu_speed_t cpu_speed
);

  int fail_count = 0;

  // Data port write strobe is a single cycle pulse
  regwr_single : assert property (@(posedge clk) disable iff (!rst_n) regwr |=> !regwr)
    else begin
      $error("regwr stayed high for two cycles");
      fail_count++;
    end

  // A bus access is either a read or a write
  rd_wr_exclusive : assert property (@(posedge clk) disable iff (!rst_n) !(regrd && regwr))
    else begin
      $error("regrd and regwr high together");
      fail_count++;
    end

  turbo_forces_speed : assert property (@(posedge clk) disable iff (!rst_n)
    turbo_boost |-> (cpu_speed == TURBO_SPEED))
    else begin
      $error("cpu_speed not forced while turbo_boost is held");
      fail_count++;
    end

endmodule

bind zxuno_io_top zxuno_io_asserts u_asserts (
  .clk         (clk),
  .rst_n       (rst_n),
  .regwr       (regbus.regwr),
  .regrd       (regbus.regrd),
  .turbo_boost (turbo_boost),
  .cpu_speed   (cpu_speed)
);

`default_nettype wire

//--- verilog/coreid_reg.sv
`timescale 1ns/1ns
`default_nettype none

module coreid_reg import zxuno_pkg::*; #(
  parameter int                       CORE_ID_LEN = 8,
  parameter logic [8*CORE_ID_LEN-1:0] CORE_ID     = "ZXUNO-IO"
) (
  input  logic  clk,
  input  logic  rst_n,
  zxreg_if.dev  bus,
  output data_t dout,
  output logic  oe
);

  localparam int IDX_W = $clog2(CORE_ID_LEN + 1);

  logic             selected;
  logic             regrd_q;
  logic [IDX_W-1:0] index;
  data_t            char;

  assign selected = (bus.regaddr == REG_COREID);

  // Index steps once the read strobe drops, stops one past the last character
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regrd_q <= 1'b0;
      index   <= '0;
    end else begin
      regrd_q <= bus.regrd;
      if (bus.regaddr_changed) begin
        index <= '0;
      end else if (regrd_q && !bus.regrd && selected && index != IDX_W'(CORE_ID_LEN)) begin
        index <= index + 1'b1;
      end
    end
  end

  // First character sits in the top byte
  always_comb begin
    char = 8'h00;
    for (int i = 0; i < CORE_ID_LEN; i++) begin
      if (index == IDX_W'(i)) begin
        char = CORE_ID[8*(CORE_ID_LEN-1-i) +: 8];
      end
    end
  end

  assign dout = char;
  assign oe   = bus.regrd && selected;

endmodule

`default_nettype wire

//--- verilog/cpu_data_mux.sv
`timescale 1ns/1ns
`default_nettype none

module cpu_data_mux import zxuno_pkg::*; (
  input  logic  iorq_n,
  input  logic  m1_n,
  input  data_t port_dout,
  input  data_t coreid_dout,
  input  data_t opt_dout,
  input  data_t scndbl_dout,
  input  logic  port_oe,
  input  logic  coreid_oe,
  input  logic  opt_oe,
  input  logic  scndbl_oe,
  output data_t dout
);

  // Interrupt acknowledge cycle
  logic intack_oe;

  assign intack_oe = !iorq_n && !m1_n;

  // First enabled source in the list wins
  always_comb begin
    case (1'b1)
      intack_oe : dout = INTACK_VALUE;
      port_oe   : dout = port_dout;
      coreid_oe : dout = coreid_dout;
      opt_oe    : dout = opt_dout;
      scndbl_oe : dout = scndbl_dout;
      default   : dout = IDLE_BUS_VALUE;
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/option_regs.sv
`timescale 1ns/1ns
`default_nettype none

module option_regs import zxuno_pkg::*; (
  input  logic  clk,
  input  logic  rst_n,
  zxreg_if.dev  bus,
  output data_t dout,
  output logic  oe,
  output data_t dev_options
);

  // ----------------------------------------------------------
  // Address match
  // ----------------------------------------------------------
  logic sel_scratch;
  logic sel_devopt;

  assign sel_scratch = (bus.regaddr == REG_SCRATCH);
  assign sel_devopt  = (bus.regaddr == REG_DEVOPTIONS);

  // ----------------------------------------------------------
  // Storage
  // ----------------------------------------------------------
  data_t scratch_q;
  data_t devopt_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      scratch_q <= '0;
      devopt_q  <= '0;
    end else if (bus.regwr) begin
      if (sel_scratch) begin
        scratch_q <= bus.wdata;
      end
      if (sel_devopt) begin
        devopt_q <= bus.wdata;
      end
    end
  end

  // ----------------------------------------------------------
  // Readback
  // ----------------------------------------------------------
  always_comb begin
    if (sel_scratch) begin
      dout = scratch_q;
    end else begin
      dout = devopt_q;
    end
  end

  assign oe          = bus.regrd && (sel_scratch || sel_devopt);
  assign dev_options = devopt_q;

endmodule

`default_nettype wire

//--- verilog/scandoubler_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module scandoubler_ctrl import zxuno_pkg::*; #(
  parameter logic [7:0] SCNDBL_RESET = 8'h00
) (
  input  logic       clk,
  input  logic       rst_n,
  zxreg_if.dev       bus,
  input  logic       video_output_change,
  input  logic       turbo_boost,
  output data_t      dout,
  output logic       oe,
  output logic       vga_enable,
  output logic       scanlines_enable,
  output logic       csync_option,
  output freq_opt_t  freq_option,
  output cpu_speed_t cpu_speed
);

  // ----------------------------------------------------------
  // Control byte
  // ----------------------------------------------------------
  // 7:6 cpu speed, 5 csync, 4:2 vertical freq,
  // 1 scanlines, 0 vga
  data_t ctrl_q;
  logic  selected;

  assign selected = (bus.regaddr == REG_SCNDBLCTRL);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      ctrl_q <= SCNDBL_RESET;
    end else if (bus.regwr && selected) begin
      // CPU write beats the keyboard
      ctrl_q <= bus.wdata;
    end else if (video_output_change) begin
      ctrl_q[0] <= ~ctrl_q[0];
    end
  end

  // ----------------------------------------------------------
  // Field outputs
  // ----------------------------------------------------------
  assign vga_enable       = ctrl_q[0];
  assign scanlines_enable = ctrl_q[1];
  assign freq_option      = ctrl_q[4:2];
  assign csync_option     = ctrl_q[5];

  // Turbo only affects the output, stored speed bits stay put
  always_comb begin
    if (turbo_boost) begin
      cpu_speed = TURBO_SPEED;
    end else begin
      cpu_speed = ctrl_q[7:6];
    end
  end

  assign dout = ctrl_q;
  assign oe   = bus.regrd && selected;

endmodule

`default_nettype wire

//--- verilog/zxreg_if.sv
`timescale 1ns/1ns
`default_nettype none

// ZX-Uno register bus, port decoder to register devices
interface zxreg_if import zxuno_pkg::*; ();

  // Current register number
  regaddr_t regaddr;
  // High while FD3B is being read
  logic     regrd;
  // Single cycle strobes
  logic     regwr;
  logic     regaddr_changed;
  // Byte written by the CPU
  data_t    wdata;

  modport host (
    output regaddr, regrd, regwr, regaddr_changed, wdata
  );

  modport dev (
    input regaddr, regrd, regwr, regaddr_changed, wdata
  );

endinterface

`default_nettype wire

//--- verilog/zxuno_io_top.sv
`timescale 1ns/1ns
`default_nettype none

module zxuno_io_top import zxuno_pkg::*; #(
  parameter int                       CORE_ID_LEN  = 8,
  parameter logic [8*CORE_ID_LEN-1:0] CORE_ID      = "ZXUNO-IO",
  parameter logic [7:0]               SCNDBL_RESET = 8'h21
) (
  // CPU bus
  input  logic       clk,
  input  logic       rst_n,
  input  cpu_addr_t  a,
  input  logic       iorq_n,
  input  logic       rd_n,
  input  logic       wr_n,
  input  logic       m1_n,
  input  data_t      din,
  output data_t      dout,

  // Keyboard shortcuts
  input  logic       video_output_change,
  input  logic       turbo_boost,

  // Control outputs
  output logic       vga_enable,
  output logic       scanlines_enable,
  output freq_opt_t  freq_option,
  output logic       csync_option,
  output cpu_speed_t cpu_speed,
  output data_t      dev_options
);

  // ----------------------------------------------------------
  // Register bus and device read paths
  // ----------------------------------------------------------
  zxreg_if regbus ();

  data_t port_dout;
  data_t coreid_dout;
  data_t opt_dout;
  data_t scndbl_dout;
  logic  port_oe;
  logic  coreid_oe;
  logic  opt_oe;
  logic  scndbl_oe;

  zxuno_reg_port u_reg_port (
    .clk    (clk),
    .rst_n  (rst_n),
    .a      (a),
    .iorq_n (iorq_n),
    .rd_n   (rd_n),
    .wr_n   (wr_n),
    .din    (din),
    .dout   (port_dout),
    .oe     (port_oe),
    .bus    (regbus.host)
  );

  coreid_reg #(
    .CORE_ID_LEN (CORE_ID_LEN),
    .CORE_ID     (CORE_ID)
  ) u_coreid (
    .clk   (clk),
    .rst_n (rst_n),
    .bus   (regbus.dev),
    .dout  (coreid_dout),
    .oe    (coreid_oe)
  );

  option_regs u_options (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus         (regbus.dev),
    .dout        (opt_dout),
    .oe          (opt_oe),
    .dev_options (dev_options)
  );

  scandoubler_ctrl #(
    .SCNDBL_RESET (SCNDBL_RESET)
  ) u_scndbl (
    .clk                 (clk),
    .rst_n               (rst_n),
    .bus                 (regbus.dev),
    .video_output_change (video_output_change),
    .turbo_boost         (turbo_boost),
    .dout                (scndbl_dout),
    .oe                  (scndbl_oe),
    .vga_enable          (vga_enable),
    .scanlines_enable    (scanlines_enable),
    .csync_option        (csync_option),
    .freq_option         (freq_option),
    .cpu_speed           (cpu_speed)
  );

  cpu_data_mux u_data_mux (
    .iorq_n      (iorq_n),
    .m1_n        (m1_n),
    .port_dout   (port_dout),
    .coreid_dout (coreid_dout),
    .opt_dout    (opt_dout),
    .scndbl_dout (scndbl_dout),
    .port_oe     (port_oe),
    .coreid_oe   (coreid_oe),
    .opt_oe      (opt_oe),
    .scndbl_oe   (scndbl_oe),
    .dout        (dout)
  );

endmodule

`default_nettype wire

//--- verilog/zxuno_pkg.sv
`default_nettype none

package zxuno_pkg;

  // ----------------------------------------------------------
  // Bus types
  // ----------------------------------------------------------
  typedef logic [7:0]  data_t;
  typedef logic [15:0] cpu_addr_t;
  typedef logic [7:0]  regaddr_t;
  typedef logic [1:0]  cpu_speed_t;
  typedef logic [2:0]  freq_opt_t;

  // ----------------------------------------------------------
  // I/O ports and register numbers
  // ----------------------------------------------------------
  localparam cpu_addr_t ZXUNO_ADDR_PORT = 16'hFC3B;
  localparam cpu_addr_t ZXUNO_DATA_PORT = 16'hFD3B;

  localparam regaddr_t REG_SCNDBLCTRL = 8'h0B;
  localparam regaddr_t REG_DEVOPTIONS = 8'h0E;
  localparam regaddr_t REG_SCRATCH    = 8'hFE;
  localparam regaddr_t REG_COREID     = 8'hFF;

  // Data bus values when nobody else drives it
  localparam data_t INTACK_VALUE   = 8'hFF;
  localparam data_t IDLE_BUS_VALUE = 8'hFF;

  // Forced while the turbo key is held
  localparam cpu_speed_t TURBO_SPEED = 2'b11;

endpackage

`default_nettype wire

//--- verilog/zxuno_reg_port.sv
`timescale 1ns/1ns
`default_nettype none

module zxuno_reg_port import zxuno_pkg::*; (
  input  logic      clk,
  input  logic      rst_n,
  input  cpu_addr_t a,
  input  logic      iorq_n,
  input  logic      rd_n,
  input  logic      wr_n,
  input  data_t     din,
  output data_t     dout,
  output logic      oe,
  zxreg_if.host     bus
);

  // ----------------------------------------------------------
  // Port decode
  // ----------------------------------------------------------
  logic io_rd;
  logic io_wr;
  logic addr_port_rd;
  logic addr_port_wr;
  logic data_port_rd;
  logic data_port_wr;

  assign io_rd = !iorq_n && !rd_n;
  assign io_wr = !iorq_n && !wr_n;

  assign addr_port_rd = io_rd && (a == ZXUNO_ADDR_PORT);
  assign addr_port_wr = io_wr && (a == ZXUNO_ADDR_PORT);
  assign data_port_rd = io_rd && (a == ZXUNO_DATA_PORT);
  assign data_port_wr = io_wr && (a == ZXUNO_DATA_PORT);

  // ----------------------------------------------------------
  // Strobe edge detect and register number latch
  // ----------------------------------------------------------
  regaddr_t regaddr_q;
  logic     addr_wr_q;
  logic     data_wr_q;
  logic     addr_wr_first;

  // Write strobes are held for several clocks, act on the first one only
  assign addr_wr_first = addr_port_wr && !addr_wr_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      regaddr_q <= '0;
      addr_wr_q <= 1'b0;
      data_wr_q <= 1'b0;
    end else begin
      addr_wr_q <= addr_port_wr;
      data_wr_q <= data_port_wr;
      if (addr_wr_first) begin
        regaddr_q <= din;
      end
    end
  end

  assign bus.regaddr         = regaddr_q;
  assign bus.regaddr_changed = addr_wr_first;
  assign bus.regwr           = data_port_wr && !data_wr_q;
  assign bus.regrd           = data_port_rd;
  assign bus.wdata           = din;

  // Readback of the register number on FC3B
  assign dout = regaddr_q;
  assign oe   = addr_port_rd;

endmodule

`default_nettype wire
